// ==== common/cpu_pkg.sv ====
// cpu package
// shared widths, instruction field codes, ALU operations and exception codes
// for the three-stage MIPS32 subset pipeline

`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;        // data, results and program counter
    typedef logic [31:0] instr_t;       // raw instruction word
    typedef logic [4:0]  reg_addr_t;    // register index
    typedef logic [2:0]  alu_op_t;      // ALU operation select
    typedef logic [1:0]  exc_code_t;    // exception reported on commit

    // ALU operations
    localparam alu_op_t ALU_ADD = 3'd0;     // also used by addi
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd4;     // signed compare

    // exception codes, first one detected wins
    localparam exc_code_t EXC_NONE       = 2'd0;
    localparam exc_code_t EXC_ILLEGAL    = 2'd1;   // decode
    localparam exc_code_t EXC_OVERFLOW   = 2'd2;   // execute
    localparam exc_code_t EXC_ZERO_WRITE = 2'd3;   // writeback

    // opcode field, bits 31:26
    localparam logic [5:0] OPC_RTYPE = 6'h00;
    localparam logic [5:0] OPC_ADDI  = 6'h08;

    // function field of R-type, bits 5:0
    localparam logic [5:0] FUNCT_ADD = 6'h20;
    localparam logic [5:0] FUNCT_SUB = 6'h22;
    localparam logic [5:0] FUNCT_AND = 6'h24;
    localparam logic [5:0] FUNCT_OR  = 6'h25;
    localparam logic [5:0] FUNCT_SLT = 6'h2A;

    localparam reg_addr_t REG_ZERO = 5'd0;  // hard-wired zero register

endpackage

`default_nettype wire

// ==== execute/alu.sv ====
// integer ALU
// add, sub, and, or and signed set-less-than, with signed overflow
// reported for add and sub

`timescale 1ns/100ps
`default_nettype none

module alu
    import cpu_pkg::*;
(
    input  wire alu_op_t op,
    input  wire word_t   a,
    input  wire word_t   b,
    output word_t        result,
    output logic         overflow
);

    word_t sum;
    word_t diff;
    logic  add_ovf;
    logic  sub_ovf;
    logic  less;

    assign sum  = a + b;
    assign diff = a - b;

    // same signs in, different sign out
    assign add_ovf = (a[31] == b[31]) && (sum[31] != a[31]);
    // different signs in, result sign differs from a
    assign sub_ovf = (a[31] != b[31]) && (diff[31] != a[31]);

    assign less = ($signed(a) < $signed(b));

    always_comb
    begin
        overflow = 1'b0;
        case (op)
            ALU_ADD:
            begin
                result   = sum;
                overflow = add_ovf;
            end
            ALU_SUB:
            begin
                result   = diff;
                overflow = sub_ovf;
            end
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLT: result = {31'd0, less};
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== decode/reg_file.sv ====
// register file
// 32 registers, two read ports with write-through, one write port;
// register zero always reads zero

`timescale 1ns/100ps
`default_nettype none

module reg_file
    import cpu_pkg::*;
(
    input  wire logic      SYS_clk,
    input  wire logic      SYS_reset,
    input  wire reg_addr_t rd_addr_a,
    input  wire reg_addr_t rd_addr_b,
    output word_t          rd_data_a,
    output word_t          rd_data_b,
    input  wire logic      wr_en,
    input  wire reg_addr_t wr_addr,
    input  wire word_t     wr_data
);

    word_t regs [32];

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wr_en && (wr_addr != REG_ZERO))
            regs[wr_addr] <= wr_data;
    end

    // same-cycle write is seen by decode
    assign rd_data_a = (rd_addr_a == REG_ZERO) ? '0 :
                       (wr_en && (wr_addr == rd_addr_a)) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == REG_ZERO) ? '0 :
                       (wr_en && (wr_addr == rd_addr_b)) ? wr_data : regs[rd_addr_b];

    // writeback turns such writes into an exception
    a_no_zero_write: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        wr_en |-> (wr_addr != REG_ZERO));

endmodule

`default_nettype wire

// ==== decode/decode_stage.sv ====
// decode stage
// accepts instructions from the input stream, numbers them with the PC,
// decodes them for execute and stalls on a dependency with execute

`timescale 1ns/100ps
`default_nettype none

module decode_stage
    import cpu_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0040_0000
)
(
    input  wire logic      SYS_clk,
    input  wire logic      SYS_reset,
    input  wire logic      instr_valid,
    input  wire instr_t    instr,
    output logic           instr_ready,
    input  wire logic      ex_advance,
    input  wire reg_addr_t x_dest,
    input  wire logic      x_write,
    input  wire logic      x_valid,
    output reg_addr_t      rd_addr_a,
    output reg_addr_t      rd_addr_b,
    input  wire word_t     rd_data_a,
    input  wire word_t     rd_data_b,
    output logic           d_valid,
    output word_t          d_pc,
    output alu_op_t        d_op,
    output word_t          d_src_a,
    output word_t          d_src_b,
    output word_t          d_imm,
    output logic           d_use_imm,
    output reg_addr_t      d_dest,
    output logic           d_write,
    output exc_code_t      d_exc
);

    instr_t     instr_q;        // held instruction
    word_t      pc_q;           // its PC
    word_t      next_pc;        // PC for the next accepted instruction
    logic       dec_valid;
    logic       hazard;
    logic       dec_move;
    logic       legal;
    logic       is_rtype;
    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;

    assign opcode   = instr_q[31:26];
    assign rs       = instr_q[25:21];
    assign rt       = instr_q[20:16];
    assign rd       = instr_q[15:11];
    assign funct    = instr_q[5:0];
    assign is_rtype = (opcode == OPC_RTYPE);

    // rt only counts as a source for R-type
    assign hazard = dec_valid && x_valid && x_write &&
                    ((x_dest == rs) || (is_rtype && (x_dest == rt)));

    assign dec_move    = dec_valid && ex_advance && !hazard;
    assign instr_ready = !dec_valid || dec_move;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            dec_valid <= 1'b0;
            next_pc   <= RESET_PC;
        end
        else if (instr_valid && instr_ready)
        begin
            dec_valid <= 1'b1;
            next_pc   <= next_pc + 32'd4;
        end
        else if (dec_move)
            dec_valid <= 1'b0;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (instr_valid && instr_ready)
        begin
            instr_q <= instr;
            pc_q    <= next_pc;
        end
    end

    always_comb
    begin
        legal     = 1'b1;
        d_op      = ALU_ADD;
        d_use_imm = 1'b0;
        if (is_rtype)
        begin
            case (funct)
                FUNCT_ADD: d_op = ALU_ADD;
                FUNCT_SUB: d_op = ALU_SUB;
                FUNCT_AND: d_op = ALU_AND;
                FUNCT_OR:  d_op = ALU_OR;
                FUNCT_SLT: d_op = ALU_SLT;
                default:   legal = 1'b0;    // unknown function code
            endcase
        end
        else if (opcode == OPC_ADDI)
            d_use_imm = 1'b1;
        else
            legal = 1'b0;                   // unsupported opcode
    end

    assign rd_addr_a = rs;
    assign rd_addr_b = rt;

    assign d_valid = dec_valid && !hazard;  // bubble while stalled
    assign d_pc    = pc_q;
    assign d_src_a = rd_data_a;
    assign d_src_b = rd_data_b;
    assign d_imm   = {{16{instr_q[15]}}, instr_q[15:0]};
    assign d_dest  = is_rtype ? rd : rt;
    assign d_write = legal;
    assign d_exc   = legal ? EXC_NONE : EXC_ILLEGAL;

    // an interlock stall lasts one cycle once execute moves on
    a_stall_one_cycle: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        hazard && ex_advance |=> !hazard);

endmodule

`default_nettype wire

// ==== execute/execute_stage.sv ====
// execute stage
// registers the decoded instruction, picks operand B and runs the ALU;
// signed overflow turns into an exception when none is pending

`timescale 1ns/100ps
`default_nettype none

module execute_stage
    import cpu_pkg::*;
(
    input  wire logic      SYS_clk,
    input  wire logic      SYS_reset,
    input  wire logic      wb_advance,
    output logic           ex_advance,
    input  wire logic      d_valid,
    input  wire word_t     d_pc,
    input  wire alu_op_t   d_op,
    input  wire word_t     d_src_a,
    input  wire word_t     d_src_b,
    input  wire word_t     d_imm,
    input  wire logic      d_use_imm,
    input  wire reg_addr_t d_dest,
    input  wire logic      d_write,
    input  wire exc_code_t d_exc,
    output logic           x_valid,
    output word_t          x_pc,
    output word_t          x_result,
    output reg_addr_t      x_dest,
    output logic           x_write,
    output exc_code_t      x_exc
);

    alu_op_t   op_q;
    word_t     src_a_q;
    word_t     src_b_q;
    word_t     imm_q;
    logic      use_imm_q;
    logic      write_q;
    exc_code_t exc_q;
    word_t     operand_b;
    logic      overflow;

    assign ex_advance = wb_advance;     // single advance decision per boundary

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            x_valid <= 1'b0;
        else if (wb_advance)
            x_valid <= d_valid;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (wb_advance)
        begin
            x_pc      <= d_pc;
            op_q      <= d_op;
            src_a_q   <= d_src_a;
            src_b_q   <= d_src_b;
            imm_q     <= d_imm;
            use_imm_q <= d_use_imm;
            x_dest    <= d_dest;
            write_q   <= d_write;
            exc_q     <= d_exc;
        end
    end

    assign operand_b = use_imm_q ? imm_q : src_b_q;    // addi takes the immediate

    alu alu_i (
        .op       (op_q),
        .a        (src_a_q),
        .b        (operand_b),
        .result   (x_result),
        .overflow (overflow)
    );

    // an earlier exception is kept as is
    assign x_exc   = (exc_q != EXC_NONE) ? exc_q :
                     overflow ? EXC_OVERFLOW : EXC_NONE;
    assign x_write = write_q && (x_exc == EXC_NONE);

endmodule

`default_nettype wire

// ==== hw/writeback_stage.sv ====
// writeback stage
// holds a finished instruction until commit, flags writes to register zero
// and drives the register file write port on the commit transfer

`timescale 1ns/100ps
`default_nettype none

module writeback_stage
    import cpu_pkg::*;
(
    input  wire logic      SYS_clk,
    input  wire logic      SYS_reset,
    input  wire logic      x_valid,
    input  wire word_t     x_pc,
    input  wire word_t     x_result,
    input  wire reg_addr_t x_dest,
    input  wire logic      x_write,
    input  wire exc_code_t x_exc,
    output logic           wb_advance,
    output logic           commit_valid,
    input  wire logic      commit_ready,
    output word_t          commit_pc,
    output reg_addr_t      commit_dest,
    output word_t          commit_data,
    output logic           commit_write,
    output exc_code_t      commit_exc,
    output logic           wr_en,
    output reg_addr_t      wr_addr,
    output word_t          wr_data
);

    logic      write_q;
    exc_code_t exc_q;

    assign wb_advance = !commit_valid || commit_ready;     // empty or committing

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            commit_valid <= 1'b0;
        else if (wb_advance)
            commit_valid <= x_valid;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (wb_advance)
        begin
            commit_pc   <= x_pc;
            commit_data <= x_result;
            commit_dest <= x_dest;
            write_q     <= x_write;
            exc_q       <= x_exc;
        end
    end

    assign commit_exc   = (exc_q != EXC_NONE) ? exc_q :
                          (write_q && (commit_dest == REG_ZERO)) ? EXC_ZERO_WRITE : EXC_NONE;
    assign commit_write = write_q && (commit_exc == EXC_NONE);

    assign wr_en   = commit_valid && commit_ready && commit_write;
    assign wr_addr = commit_dest;
    assign wr_data = commit_data;

    // held commit must not change until taken
    a_commit_stable: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit_pc) &&
        $stable(commit_dest) && $stable(commit_data) && $stable(commit_write) &&
        $stable(commit_exc));

endmodule

`default_nettype wire

// ==== hw/pipeline_core.sv ====
// pipeline core
// three-stage MIPS32 subset pipeline: decode, execute and writeback,
// with the register file read from decode and written at commit

`timescale 1ns/100ps
`default_nettype none

module pipeline_core
    import cpu_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0040_0000
)
(
    input  wire logic      SYS_clk,
    input  wire logic      SYS_reset,
    input  wire logic      instr_valid,
    input  wire instr_t    instr,
    output logic           instr_ready,
    output logic           commit_valid,
    input  wire logic      commit_ready,
    output word_t          commit_pc,
    output reg_addr_t      commit_dest,
    output word_t          commit_data,
    output logic           commit_write,
    output exc_code_t      commit_exc
);

    // decode to execute
    logic      d_valid;
    word_t     d_pc;
    alu_op_t   d_op;
    word_t     d_src_a;
    word_t     d_src_b;
    word_t     d_imm;
    logic      d_use_imm;
    reg_addr_t d_dest;
    logic      d_write;
    exc_code_t d_exc;

    // execute to writeback
    logic      x_valid;
    word_t     x_pc;
    word_t     x_result;
    reg_addr_t x_dest;
    logic      x_write;
    exc_code_t x_exc;

    // back-pressure
    logic      wb_advance;
    logic      ex_advance;

    // register file ports
    reg_addr_t rd_addr_a;
    reg_addr_t rd_addr_b;
    word_t     rd_data_a;
    word_t     rd_data_b;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    decode_stage #(
        .RESET_PC (RESET_PC)
    ) decode_stage_i (.*);

    reg_file reg_file_i (.*);

    execute_stage execute_stage_i (.*);

    writeback_stage writeback_stage_i (.*);

endmodule

`default_nettype wire

// ==== dv/tb_pipeline_core.sv ====
// pipeline core testbench
// drives instructions into the pipeline, predicts each commit from a register
// model in program order and checks the commit stream against it

`timescale 1ns/100ps
`default_nettype none

module tb_pipeline_core
    import cpu_pkg::*;
;

    localparam word_t RESET_PC = 32'h0040_0000;
    localparam int    TIMEOUT  = 500;           // cycles per wait

    logic      SYS_clk;
    logic      SYS_reset;
    logic      instr_valid;
    instr_t    instr;
    logic      instr_ready;
    logic      commit_valid;
    logic      commit_ready;
    word_t     commit_pc;
    reg_addr_t commit_dest;
    word_t     commit_data;
    logic      commit_write;
    exc_code_t commit_exc;

    integer    seed;
    int        value_errors;
    int        other_errors;
    int        commits;
    logic      timed_out;
    logic      bp_enable;                       // random commit_ready
    logic      ready_next;                      // commit_ready for the coming cycle

    word_t     model [32];                      // architectural registers
    word_t     exp_pc;
    word_t     q_pc [$];
    reg_addr_t q_dest [$];
    word_t     q_data [$];
    logic      q_write [$];
    exc_code_t q_exc [$];

    logic      held;                            // commit stalled at last check
    word_t     held_pc;
    reg_addr_t held_dest;
    word_t     held_data;
    logic      held_write;
    exc_code_t held_exc;

    pipeline_core #(
        .RESET_PC (RESET_PC)
    ) pipeline_core_i (.*);

    always #50 SYS_clk = ~SYS_clk;

    always @(posedge SYS_clk)
    begin
        // drawn at the edge, driven just after it
        if (bp_enable)
            ready_next = 1'($random(seed));
        else
            ready_next = 1'b1;
        #1;
        commit_ready = ready_next;
    end

    function automatic instr_t enc_r(input logic [5:0] funct, input int rd, input int rs,
                                     input int rt);
        return {OPC_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
    endfunction

    function automatic instr_t enc_i(input logic [5:0] opc, input int rt, input int rs,
                                     input logic [15:0] imm);
        return {opc, 5'(rs), 5'(rt), imm};
    endfunction

    // expected commit of one instruction, applied to the model in order
    task automatic predict(input instr_t w);
        logic [5:0] opc;
        logic [5:0] funct;
        reg_addr_t  dest;
        longint     sa;
        longint     sb;
        longint     wide;
        word_t      res;
        logic       legal;
        logic       ovf;
        exc_code_t  exc;
        opc   = w[31:26];
        funct = w[5:0];
        dest  = (opc == OPC_RTYPE) ? w[15:11] : w[20:16];
        sa    = longint'($signed(model[w[25:21]]));
        sb    = (opc == OPC_RTYPE) ? longint'($signed(model[w[20:16]])) :
                longint'($signed(w[15:0]));
        legal = 1'b1;
        wide  = 0;
        if (opc == OPC_ADDI || (opc == OPC_RTYPE && funct == FUNCT_ADD))
            wide = sa + sb;
        else if (opc == OPC_RTYPE && funct == FUNCT_SUB)
            wide = sa - sb;
        else if (opc == OPC_RTYPE && funct == FUNCT_AND)
            wide = sa & sb;
        else if (opc == OPC_RTYPE && funct == FUNCT_OR)
            wide = sa | sb;
        else if (opc == OPC_RTYPE && funct == FUNCT_SLT)
            wide = (sa < sb) ? 1 : 0;
        else
            legal = 1'b0;
        res = wide[31:0];
        ovf = (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
        if (!legal)
            exc = EXC_ILLEGAL;
        else if (ovf)
            exc = EXC_OVERFLOW;
        else if (dest == 5'd0)
            exc = EXC_ZERO_WRITE;
        else
            exc = EXC_NONE;
        if (exc == EXC_NONE)
            model[dest] = res;
        q_pc.push_back(exp_pc);
        q_dest.push_back(dest);
        q_data.push_back(res);
        q_write.push_back(exc == EXC_NONE);
        q_exc.push_back(exc);
        exp_pc = exp_pc + 32'd4;
    endtask

    // checks sampled mid-cycle, where all outputs are settled
    always @(negedge SYS_clk)
    begin
        if (!SYS_reset)
        begin
            if (held)
            begin
                assert (commit_valid) else
                begin
                    $display("held commit dropped commit_valid before transfer");
                    other_errors++;
                end
                assert (commit_pc == held_pc && commit_dest == held_dest &&
                        commit_data == held_data && commit_write == held_write &&
                        commit_exc == held_exc) else
                begin
                    $display("FAILED held commit changed pc %h->%h data %h->%h",
                             held_pc, commit_pc, held_data, commit_data);
                    value_errors++;
                end
            end
            if (commit_valid && commit_ready)
            begin
                if (q_pc.size() == 0)
                begin
                    $display("commit seen with no instruction outstanding");
                    other_errors++;
                end
                else
                begin
                    assert (commit_pc == q_pc[0]) else
                    begin
                        $display("FAILED commit_pc got %h expected %h", commit_pc, q_pc[0]);
                        value_errors++;
                    end
                    assert (commit_dest == q_dest[0]) else
                    begin
                        $display("FAILED commit_dest got %h expected %h",
                                 commit_dest, q_dest[0]);
                        value_errors++;
                    end
                    assert (commit_exc == q_exc[0]) else
                    begin
                        $display("FAILED commit_exc got %h expected %h", commit_exc, q_exc[0]);
                        value_errors++;
                    end
                    assert (commit_write == q_write[0]) else
                    begin
                        $display("FAILED commit_write got %h expected %h",
                                 commit_write, q_write[0]);
                        value_errors++;
                    end
                    // result only matters when it is written
                    assert (q_exc[0] != EXC_NONE || commit_data == q_data[0]) else
                    begin
                        $display("FAILED commit_data got %h expected %h",
                                 commit_data, q_data[0]);
                        value_errors++;
                    end
                    void'(q_pc.pop_front());
                    void'(q_dest.pop_front());
                    void'(q_data.pop_front());
                    void'(q_write.pop_front());
                    void'(q_exc.pop_front());
                    commits++;
                end
            end
            if (instr_valid && instr_ready)
                predict(instr);
            held       = commit_valid && !commit_ready;
            held_pc    = commit_pc;
            held_dest  = commit_dest;
            held_data  = commit_data;
            held_write = commit_write;
            held_exc   = commit_exc;
        end
    end

    // offer one instruction and hold it until accepted
    task automatic send_instr(input instr_t w);
        int cnt;
        logic taken;
        cnt   = 0;
        taken = 1'b0;
        if (!timed_out)
        begin
            instr_valid = 1'b1;
            instr       = w;
            while (!taken && cnt < TIMEOUT)
            begin
                @(negedge SYS_clk);
                taken = instr_ready;
                if (!taken)
                begin
                    @(posedge SYS_clk);
                    cnt++;
                end
            end
            if (!taken)
            begin
                $display("timeout: instruction %h never accepted", w);
                timed_out = 1'b1;
            end
            @(posedge SYS_clk);
            #1;
            instr_valid = 1'b0;
        end
    endtask

    task automatic drain_commits();
        int cnt;
        cnt = 0;
        while (!timed_out && q_pc.size() != 0 && cnt < TIMEOUT)
        begin
            @(posedge SYS_clk);
            cnt++;
        end
        if (!timed_out && q_pc.size() != 0)
        begin
            $display("timeout: %0d commits still outstanding", q_pc.size());
            timed_out = 1'b1;
        end
        #1;
    endtask

    initial
    begin
        SYS_clk      = 1'b0;
        SYS_reset    = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        commit_ready = 1'b1;
        bp_enable    = 1'b0;
        seed         = 32'h6ee8;
        value_errors = 0;
        other_errors = 0;
        commits      = 0;
        timed_out    = 1'b0;
        held         = 1'b0;
        exp_pc       = RESET_PC;
        for (int i = 0; i < 32; i++)
            model[i] = '0;
        repeat (10) @(posedge SYS_clk);
        #1;
        SYS_reset = 1'b0;
        @(negedge SYS_clk);
        assert (!commit_valid && instr_ready) else
        begin
            $display("after reset commit_valid or instr_ready has the wrong level");
            other_errors++;
        end
        @(posedge SYS_clk);
        #1;

        // ALU operations on independent registers
        for (int r = 1; r <= 8; r++)
            send_instr(enc_i(OPC_ADDI, r, 0, 16'($random(seed))));
        send_instr(enc_r(FUNCT_ADD, 9, 1, 2));
        send_instr(enc_r(FUNCT_SUB, 10, 3, 4));
        send_instr(enc_r(FUNCT_AND, 11, 5, 6));
        send_instr(enc_r(FUNCT_OR, 12, 7, 8));
        send_instr(enc_r(FUNCT_SLT, 13, 1, 2));
        send_instr(enc_r(FUNCT_SLT, 14, 3, 4));
        drain_commits();

        // dependency chain through rs and rt
        send_instr(enc_i(OPC_ADDI, 20, 0, 16'd5));
        for (int k = 0; k < 6; k++)
            send_instr(enc_r(FUNCT_ADD, 20, 20, 20));
        send_instr(enc_r(FUNCT_SUB, 21, 20, 1));
        send_instr(enc_r(FUNCT_OR, 22, 21, 21));
        drain_commits();

        // overflow on add and addi
        send_instr(enc_i(OPC_ADDI, 23, 0, 16'h4000));
        for (int k = 0; k < 16; k++)
            send_instr(enc_r(FUNCT_ADD, 23, 23, 23));   // ends at 0x40000000
        send_instr(enc_r(FUNCT_ADD, 24, 23, 23));
        send_instr(enc_r(FUNCT_ADD, 25, 24, 0));        // r24 unchanged
        send_instr(enc_i(OPC_ADDI, 26, 23, 16'hffff));
        send_instr(enc_r(FUNCT_ADD, 26, 23, 26));       // 0x7fffffff
        send_instr(enc_i(OPC_ADDI, 27, 26, 16'd1));
        send_instr(enc_r(FUNCT_OR, 28, 27, 0));
        drain_commits();

        // illegal encodings, then zero register writes
        send_instr(enc_i(6'h23, 5, 1, 16'd4));
        send_instr(enc_r(6'h00, 5, 1, 2));
        send_instr(enc_r(6'h27, 6, 1, 2));
        send_instr(enc_i(OPC_ADDI, 0, 0, 16'd7));
        send_instr(enc_r(FUNCT_ADD, 0, 1, 2));
        send_instr(enc_r(FUNCT_ADD, 29, 0, 0));
        send_instr(enc_r(FUNCT_OR, 30, 5, 6));
        drain_commits();

        // random traffic under commit back-pressure
        bp_enable = 1'b1;
        for (int k = 0; k < 40; k++)
        begin
            int op;
            int rd;
            int rs;
            int rt;
            op = $random(seed) & 7;
            rd = 1 + (($random(seed) & 32'h7fffffff) % 15);
            rs = 1 + (($random(seed) & 32'h7fffffff) % 15);
            rt = 1 + (($random(seed) & 32'h7fffffff) % 15);
            case (op)
                0: send_instr(enc_r(FUNCT_ADD, rd, rs, rt));
                1: send_instr(enc_r(FUNCT_SUB, rd, rs, rt));
                2: send_instr(enc_r(FUNCT_AND, rd, rs, rt));
                3: send_instr(enc_r(FUNCT_OR, rd, rs, rt));
                4: send_instr(enc_r(FUNCT_SLT, rd, rs, rt));
                default: send_instr(enc_i(OPC_ADDI, rd, rs, 16'($random(seed))));
            endcase
        end
        drain_commits();
        bp_enable = 1'b0;
        repeat (3) @(posedge SYS_clk);

        $display("errors: value %0d, other %0d, timeout %0d, commits %0d",
                 value_errors, other_errors, timed_out, commits);
        if (value_errors == 0 && other_errors == 0 && !timed_out)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== pipeline_core.f ====
common/cpu_pkg.sv
execute/alu.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
hw/writeback_stage.sv
hw/pipeline_core.sv
dv/tb_pipeline_core.sv

// ==== Makefile ====
# Verilator build for the pipeline core testbench

VERILATOR ?= verilator
TOP       ?= tb_pipeline_core
FILELIST  ?= pipeline_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
